//--- logic/dcache_pkg.sv
package dcache_pkg;

	// address and data widths
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;

	// byte within a word
	localparam int BYTE_OFF_W = 2;

	// word within a line, 16 words per line
	localparam int OFFSET_W = 4;

	localparam int LINE_WORDS = 2 ** OFFSET_W;
	localparam int WORD_BYTES = WORD_W / 8;

	// one data word
	typedef logic [WORD_W-1:0] word_t;

	// one enable per byte lane
	typedef logic [WORD_BYTES-1:0] be_t;

	// word index inside a line, also the burst beat counter
	typedef logic [OFFSET_W-1:0] offset_t;

	// controller states
	// a miss walks WB_ADDR/WB_DATA (dirty victim only), then RF_ADDR/RF_DATA,
	// then REPLAY performs the original access as a hit
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RESP,
		ST_WB_ADDR,
		ST_WB_DATA,
		ST_RF_ADDR,
		ST_RF_DATA,
		ST_REPLAY
	} ctrl_state_e;

endpackage

//--- logic/dcache_tag_array.sv
`timescale 1ns/100ps

module dcache_tag_array #(
	parameter int INDEX_W = 6,
	localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
		- dcache_pkg::BYTE_OFF_W
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [INDEX_W-1:0] lookup_index,
	input  logic [TAG_W-1:0]   lookup_tag,
	output logic [1:0]         hit,
	output logic               victim_way,
	output logic [TAG_W-1:0]   victim_tag,
	output logic               victim_dirty,
	input  logic               touch,
	input  logic               touch_way,
	input  logic               set_dirty,
	input  logic               fill,
	input  logic               fill_way
);

	localparam int SETS = 2 ** INDEX_W;

	logic [TAG_W-1:0] tag_mem [2][SETS];
	logic [SETS-1:0]  valid [2];
	logic [SETS-1:0]  dirty [2];

	// one bit per set, names the least recently used way
	logic [SETS-1:0]  lru;

	// per-way compare against the lookup tag
	always_comb
	begin
		for (int w = 0; w < 2; w++)
		begin
			hit[w] = valid[w][lookup_index] && (tag_mem[w][lookup_index] == lookup_tag);
		end
	end

	assign victim_way   = lru[lookup_index];
	assign victim_tag   = tag_mem[victim_way][lookup_index];
	// only a valid dirty line needs a write-back
	assign victim_dirty = valid[victim_way][lookup_index] && dirty[victim_way][lookup_index];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int w = 0; w < 2; w++)
			begin
				valid[w] <= '0;
				dirty[w] <= '0;
				for (int s = 0; s < SETS; s++)
				begin
					tag_mem[w][s] <= '0;
				end
			end
			lru <= '0;
		end
		else
		begin
			// new line arrives clean
			if (fill)
			begin
				tag_mem[fill_way][lookup_index] <= lookup_tag;
				valid[fill_way][lookup_index]   <= 1'b1;
				dirty[fill_way][lookup_index]   <= 1'b0;
			end
			// the other way becomes the next victim
			if (touch)
			begin
				lru[lookup_index] <= ~touch_way;
				if (set_dirty)
				begin
					dirty[touch_way][lookup_index] <= 1'b1;
				end
			end
		end
	end

	// a tag lives in at most one way of a set, whatever fill and touch did before
	a_one_hit: assert property (@(posedge clk) disable iff (!rst_n) !(hit[0] && hit[1]));

endmodule

//--- logic/dcache_data_array.sv
`timescale 1ns/100ps

module dcache_data_array #(
	parameter int INDEX_W = 6
) (
	input  logic                clk,
	input  logic                rd_way,
	input  logic                wr_way,
	input  logic [INDEX_W-1:0]  index,
	input  dcache_pkg::offset_t offset,
	output dcache_pkg::word_t   rd_data,
	input  logic                we,
	input  dcache_pkg::be_t     be,
	input  dcache_pkg::word_t   wr_data
);

	import dcache_pkg::*;

	localparam int DEPTH = (2 ** INDEX_W) * LINE_WORDS;

	word_t mem [2][DEPTH];

	// set index on top, word offset below
	logic [INDEX_W+OFFSET_W-1:0] addr;

	assign addr = {index, offset};

	// only enabled lanes change
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			for (int b = 0; b < WORD_BYTES; b++)
			begin
				if (be[b])
				begin
					mem[wr_way][addr][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
	end

	// read is combinational, same address as the write port
	assign rd_data = mem[rd_way][addr];

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl #(
	parameter int INDEX_W = 6,
	localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
		- dcache_pkg::BYTE_OFF_W
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// CPU side
	input  logic                          cpu_req,
	input  logic                          cpu_we,
	input  logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
	input  dcache_pkg::be_t               cpu_be,
	input  dcache_pkg::word_t             cpu_wdata,
	output logic                          cpu_ready,
	output logic                          cpu_resp,
	output dcache_pkg::word_t             cpu_rdata,
	// memory bus
	output logic [dcache_pkg::ADDR_W-1:0] mem_araddr,
	output logic                          mem_arvalid,
	input  logic                          mem_arready,
	input  logic                          mem_rvalid,
	input  dcache_pkg::word_t             mem_rdata,
	input  logic                          mem_rlast,
	output logic [dcache_pkg::ADDR_W-1:0] mem_awaddr,
	output logic                          mem_awvalid,
	input  logic                          mem_awready,
	output logic                          mem_wvalid,
	input  logic                          mem_wready,
	output dcache_pkg::word_t             mem_wdata,
	output logic                          mem_wlast,
	// tag array
	output logic [INDEX_W-1:0]            lookup_index,
	output logic [TAG_W-1:0]              lookup_tag,
	input  logic [1:0]                    hit,
	input  logic                          victim_way,
	input  logic [TAG_W-1:0]              victim_tag,
	input  logic                          victim_dirty,
	output logic                          touch,
	output logic                          touch_way,
	output logic                          set_dirty,
	output logic                          fill,
	output logic                          fill_way,
	// data array
	output logic                          dat_rd_way,
	output logic                          dat_wr_way,
	output logic [INDEX_W-1:0]            dat_index,
	output dcache_pkg::offset_t           dat_offset,
	output logic                          dat_we,
	output dcache_pkg::be_t               dat_be,
	output dcache_pkg::word_t             dat_wdata,
	input  dcache_pkg::word_t             dat_rdata
);

	import dcache_pkg::*;

	localparam int LINE_LSB = OFFSET_W + BYTE_OFF_W;
	localparam offset_t LAST_BEAT = '1;

	ctrl_state_e state;
	offset_t cnt;

	// captured request
	logic [ADDR_W-1:0] req_addr;
	logic req_we;
	be_t req_be;
	word_t req_wdata;

	// way to refill and the tag it held before
	logic vic_way;
	logic [TAG_W-1:0] wb_tag;

	logic [ADDR_W-1:0] cur_addr;
	logic [INDEX_W-1:0] req_index;
	logic burst;

	// write beats accepted since the write address handshake
	offset_t wb_beats;

	// idle looks up the incoming address, every other state the captured one
	assign cur_addr = (state == ST_IDLE) ? cpu_addr : req_addr;
	assign req_index = req_addr[LINE_LSB +: INDEX_W];

	assign lookup_index = cur_addr[LINE_LSB +: INDEX_W];
	assign lookup_tag   = cur_addr[ADDR_W-1 -: TAG_W];
	assign dat_index    = cur_addr[LINE_LSB +: INDEX_W];

	assign burst      = (state == ST_WB_DATA) || (state == ST_RF_DATA);
	assign dat_offset = burst ? cnt : cur_addr[BYTE_OFF_W +: OFFSET_W];
	assign dat_rd_way = (state == ST_WB_DATA) ? vic_way : hit[1];
	assign fill_way   = vic_way;

	assign cpu_ready = (state == ST_IDLE);
	assign cpu_resp  = (state == ST_RESP);
	assign cpu_rdata = dat_rdata;

	// bursts are line aligned
	assign mem_araddr  = {req_addr[ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
	assign mem_awaddr  = {wb_tag, req_index, {LINE_LSB{1'b0}}};
	assign mem_arvalid = (state == ST_RF_ADDR);
	assign mem_awvalid = (state == ST_WB_ADDR);
	assign mem_wvalid  = (state == ST_WB_DATA);
	assign mem_wlast   = mem_wvalid && (cnt == LAST_BEAT);
	assign mem_wdata   = dat_rdata;

	always_comb
	begin
		touch      = 1'b0;
		touch_way  = hit[1];
		set_dirty  = 1'b0;
		fill       = 1'b0;
		dat_we     = 1'b0;
		dat_wr_way = hit[1];
		dat_be     = cpu_be;
		dat_wdata  = cpu_wdata;
		case (state)
			ST_IDLE:
			begin
				// hit completes here, store merges in place
				if (cpu_req && (hit != 2'b00))
				begin
					touch     = 1'b1;
					set_dirty = cpu_we;
					dat_we    = cpu_we;
				end
			end
			ST_RF_DATA:
			begin
				if (mem_rvalid)
				begin
					dat_we     = 1'b1;
					dat_wr_way = vic_way;
					dat_be     = '1;
					dat_wdata  = mem_rdata;
					// tag goes valid with the last word
					fill       = mem_rlast;
				end
			end
			ST_REPLAY:
			begin
				touch     = 1'b1;
				set_dirty = req_we;
				dat_we    = req_we;
				dat_be    = req_be;
				dat_wdata = req_wdata;
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (cpu_req && (state == ST_IDLE))
		begin
			req_addr  <= cpu_addr;
			req_we    <= cpu_we;
			req_be    <= cpu_be;
			req_wdata <= cpu_wdata;
			vic_way   <= victim_way;
			wb_tag    <= victim_tag;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					cnt <= '0;
					if (cpu_req)
					begin
						if (hit != 2'b00)
							state <= ST_RESP;
						else if (victim_dirty)
							state <= ST_WB_ADDR;
						else
							state <= ST_RF_ADDR;
					end
				end
				ST_RESP:
					state <= ST_IDLE;
				ST_WB_ADDR:
				begin
					if (mem_awready)
						state <= ST_WB_DATA;
				end
				ST_WB_DATA:
				begin
					if (mem_wready)
					begin
						cnt <= cnt + 1'b1;
						if (cnt == LAST_BEAT)
							state <= ST_RF_ADDR;
					end
				end
				ST_RF_ADDR:
				begin
					if (mem_arready)
						state <= ST_RF_DATA;
				end
				ST_RF_DATA:
				begin
					if (mem_rvalid)
					begin
						cnt <= cnt + 1'b1;
						if (mem_rlast)
							state <= ST_REPLAY;
					end
				end
				ST_REPLAY:
					state <= ST_RESP;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wb_beats <= '0;
		else if (mem_awvalid && mem_awready)
			wb_beats <= '0;
		else if (mem_wvalid && mem_wready)
			wb_beats <= wb_beats + 1'b1;
	end

	// CPU side must respect the stall
	a_req_ready: assert property (@(posedge clk) disable iff (!rst_n) cpu_req |-> cpu_ready);

	// address phases hold until accepted
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));
	a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_awvalid && !mem_awready |=> mem_awvalid && $stable(mem_awaddr));

	// wlast marks the 16th beat and no other
	a_wlast_beat: assert property (@(posedge clk) disable iff (!rst_n)
		mem_wvalid |-> (mem_wlast == (wb_beats == LAST_BEAT)));

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/100ps

module dcache_top #(
	parameter int INDEX_W = 6,
	localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
		- dcache_pkg::BYTE_OFF_W
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cpu_req,
	input  logic                          cpu_we,
	input  logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
	input  dcache_pkg::be_t               cpu_be,
	input  dcache_pkg::word_t             cpu_wdata,
	output logic                          cpu_ready,
	output logic                          cpu_resp,
	output dcache_pkg::word_t             cpu_rdata,
	output logic [dcache_pkg::ADDR_W-1:0] mem_araddr,
	output logic                          mem_arvalid,
	input  logic                          mem_arready,
	input  logic                          mem_rvalid,
	input  dcache_pkg::word_t             mem_rdata,
	input  logic                          mem_rlast,
	output logic [dcache_pkg::ADDR_W-1:0] mem_awaddr,
	output logic                          mem_awvalid,
	input  logic                          mem_awready,
	output logic                          mem_wvalid,
	input  logic                          mem_wready,
	output dcache_pkg::word_t             mem_wdata,
	output logic                          mem_wlast
);

	import dcache_pkg::*;

	// controller to tag array
	logic [INDEX_W-1:0] lookup_index;
	logic [TAG_W-1:0] lookup_tag;
	logic [1:0] hit;
	logic victim_way;
	logic [TAG_W-1:0] victim_tag;
	logic victim_dirty;
	logic touch;
	logic touch_way;
	logic set_dirty;
	logic fill;
	logic fill_way;

	// controller to data array
	logic dat_rd_way;
	logic dat_wr_way;
	logic [INDEX_W-1:0] dat_index;
	offset_t dat_offset;
	logic dat_we;
	be_t dat_be;
	word_t dat_wdata;
	word_t dat_rdata;

	dcache_ctrl #(
		.INDEX_W(INDEX_W)
	) i_ctrl (
		.*
	);

	dcache_tag_array #(
		.INDEX_W(INDEX_W)
	) i_tags (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.hit(hit),
		.victim_way(victim_way),
		.victim_tag(victim_tag),
		.victim_dirty(victim_dirty),
		.touch(touch),
		.touch_way(touch_way),
		.set_dirty(set_dirty),
		.fill(fill),
		.fill_way(fill_way)
	);

	dcache_data_array #(
		.INDEX_W(INDEX_W)
	) i_data (
		.clk(clk),
		.rd_way(dat_rd_way),
		.wr_way(dat_wr_way),
		.index(dat_index),
		.offset(dat_offset),
		.rd_data(dat_rdata),
		.we(dat_we),
		.be(dat_be),
		.wr_data(dat_wdata)
	);

endmodule

//--- sim/dcache_mem_slave.sv
`timescale 1ns/100ps

module dcache_mem_slave #(
	parameter int MEM_AW = 8
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [dcache_pkg::ADDR_W-1:0] araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic                          rvalid,
	output dcache_pkg::word_t             rdata,
	output logic                          rlast,
	input  logic [dcache_pkg::ADDR_W-1:0] awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic                          wvalid,
	output logic                          wready,
	input  dcache_pkg::word_t             wdata
);

	import dcache_pkg::*;

	// backing store, word addressed
	word_t mem [2**MEM_AW];

	logic [31:0] rng;
	logic rd_busy;
	logic [MEM_AW-1:0] rd_ptr;
	offset_t rd_cnt;
	logic [MEM_AW-1:0] wr_ptr;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// each word starts out as a pattern of its own address
	initial
	begin
		for (int i = 0; i < 2**MEM_AW; i++)
		begin
			mem[i] = {~i[15:0], i[15:0]};
		end
		arready = 1'b0;
		awready = 1'b0;
		wready  = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rdata   = '0;
	end

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			rng     <= 32'h37cb;
			arready <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			rvalid  <= 1'b0;
			rlast   <= 1'b0;
			rdata   <= '0;
			rd_busy <= 1'b0;
			rd_ptr  <= '0;
			rd_cnt  <= '0;
			wr_ptr  <= '0;
		end
		else
		begin
			rng <= xorshift(rng);
			// address ready after a random wait, dropped once taken
			arready <= arvalid && !arready && !rd_busy && rng[0];
			awready <= awvalid && !awready && rng[1];
			wready  <= rng[2];
			if (arvalid && arready)
			begin
				rd_busy <= 1'b1;
				rd_ptr  <= araddr[MEM_AW+1:2];
				rd_cnt  <= '0;
			end
			// ascending beats with random gaps
			rvalid <= 1'b0;
			rlast  <= 1'b0;
			if (rd_busy && (rng[3] || rng[4]))
			begin
				rvalid <= 1'b1;
				rdata  <= mem[rd_ptr];
				rlast  <= (rd_cnt == 4'hf);
				rd_ptr <= rd_ptr + 1'b1;
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == 4'hf)
					rd_busy <= 1'b0;
			end
			if (awvalid && awready)
				wr_ptr <= awaddr[MEM_AW+1:2];
			if (wvalid && wready)
			begin
				mem[wr_ptr] <= wdata;
				wr_ptr      <= wr_ptr + 1'b1;
			end
		end
	end

endmodule

//--- sim/tb_dcache.sv
`timescale 1ns/100ps

module tb_dcache;

	import dcache_pkg::*;

	localparam int INDEX_W = 2;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;
	localparam int LINE_LSB = OFFSET_W + BYTE_OFF_W;
	localparam int SETS = 2 ** INDEX_W;
	localparam int MEM_AW = 8;
	localparam int LINE_AW = MEM_AW - OFFSET_W;
	localparam int NUM_ACCESSES = 400;
	localparam int TIMEOUT = 2000;

	logic clk;
	logic rst_n;
	logic cpu_req;
	logic cpu_we;
	logic [ADDR_W-1:0] cpu_addr;
	be_t cpu_be;
	word_t cpu_wdata;
	logic cpu_ready;
	logic cpu_resp;
	word_t cpu_rdata;
	logic [ADDR_W-1:0] mem_araddr;
	logic mem_arvalid;
	logic mem_arready;
	logic mem_rvalid;
	word_t mem_rdata;
	logic mem_rlast;
	logic [ADDR_W-1:0] mem_awaddr;
	logic mem_awvalid;
	logic mem_awready;
	logic mem_wvalid;
	logic mem_wready;
	word_t mem_wdata;
	logic mem_wlast;

	// last value written to each word, as the CPU sees it
	word_t shadow [2**MEM_AW];

	// expected cache contents, two ways per set
	logic [TAG_W-1:0] model_tag [2][SETS];
	logic [SETS-1:0] model_valid [2];
	logic [SETS-1:0] model_dirty [2];
	logic [SETS-1:0] model_lru;

	logic [31:0] rng;
	logic [31:0] draw;
	int word_errors;
	int addr_errors;
	int flag_errors;
	int timeouts;

	dcache_top #(
		.INDEX_W(INDEX_W)
	) i_dut (
		.*
	);

	dcache_mem_slave #(
		.MEM_AW(MEM_AW)
	) i_mem (
		.clk(clk),
		.rst_n(rst_n),
		.araddr(mem_araddr),
		.arvalid(mem_arvalid),
		.arready(mem_arready),
		.rvalid(mem_rvalid),
		.rdata(mem_rdata),
		.rlast(mem_rlast),
		.awaddr(mem_awaddr),
		.awvalid(mem_awvalid),
		.awready(mem_awready),
		.wvalid(mem_wvalid),
		.wready(mem_wready),
		.wdata(mem_wdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act)
		begin
			word_errors++;
			$display("[FAIL] %s at %0t: expected %h, actual %h", name, $time, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
		input logic [ADDR_W-1:0] act);
		if (exp !== act)
		begin
			addr_errors++;
			$display("[FAIL] %s at %0t: expected %h, actual %h", name, $time, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			flag_errors++;
			$display("[FAIL] %s at %0t: expected %b, actual %b", name, $time, exp, act);
		end
	endtask

	// one CPU access, with the bus watched until cpu_resp
	task automatic run_access(input logic we, input logic [ADDR_W-1:0] addr, input be_t be,
		input word_t wdata);
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0] tag;
		logic [MEM_AW-1:0] word;
		logic way;
		logic exp_hit;
		logic exp_wb;
		logic [LINE_AW-1:0] wb_line;
		logic [ADDR_W-1:0] wb_addr;
		logic [ADDR_W-1:0] rf_addr;
		logic ar_seen;
		logic resp;
		int aw_seen;
		int wr_beats;
		int cycles;

		idx     = addr[LINE_LSB +: INDEX_W];
		tag     = addr[ADDR_W-1 -: TAG_W];
		word    = addr[MEM_AW+1:2];
		rf_addr = {addr[ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};

		// on a miss the LRU way is the victim
		exp_hit = 1'b0;
		way     = model_lru[idx];
		for (int w = 0; w < 2; w++)
		begin
			if (model_valid[w][idx] && (model_tag[w][idx] == tag))
			begin
				exp_hit = 1'b1;
				way     = w[0];
			end
		end
		exp_wb  = !exp_hit && model_valid[way][idx] && model_dirty[way][idx];
		wb_line = {model_tag[way][idx][LINE_AW-INDEX_W-1:0], idx};
		wb_addr = {model_tag[way][idx], idx, {LINE_LSB{1'b0}}};

		cycles = 0;
		@(negedge clk);
		while (!cpu_ready)
		begin
			cycles++;
			if (cycles > TIMEOUT)
			begin
				timeouts++;
				$display("timeout: cpu_ready stayed low");
				return;
			end
			@(negedge clk);
		end

		@(posedge clk);
		cpu_req   <= 1'b1;
		cpu_we    <= we;
		cpu_addr  <= addr;
		cpu_be    <= be;
		cpu_wdata <= wdata;
		@(posedge clk);
		cpu_req <= 1'b0;

		ar_seen  = 1'b0;
		resp     = 1'b0;
		aw_seen  = 0;
		wr_beats = 0;
		cycles   = 0;
		while (!resp)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
			begin
				timeouts++;
				$display("timeout: no cpu_resp for access to %h", addr);
				return;
			end
			// handshakes seen here complete at the next rising edge
			if (mem_awvalid && mem_awready)
			begin
				aw_seen++;
				check_addr("write-back address", wb_addr, mem_awaddr);
			end
			if (mem_wvalid && mem_wready)
			begin
				check_word("write-back data", shadow[{wb_line, wr_beats[3:0]}], mem_wdata);
				check_flag("wlast on beat 16 only", wr_beats == 15, mem_wlast);
				wr_beats++;
			end
			if (!mem_wvalid)
				check_flag("wlast outside write burst", 1'b0, mem_wlast);
			// a read burst starts as soon as its address is requested
			if (mem_arvalid)
				ar_seen = 1'b1;
			if (mem_arvalid && mem_arready)
			begin
				check_addr("refill address", rf_addr, mem_araddr);
				check_flag("write-back done before refill", 1'b1,
					wr_beats == (exp_wb ? 16 : 0));
			end
			resp = cpu_resp;
		end

		if (!we)
			check_word("read data", shadow[word], cpu_rdata);
		if (exp_hit)
		begin
			check_flag("hit response one cycle after accept", 1'b1, cycles == 1);
			check_flag("read burst on hit", 1'b0, ar_seen);
		end
		else
		begin
			check_flag("read burst on miss", 1'b1, ar_seen);
			check_flag("write-back on eviction", exp_wb, aw_seen != 0);
			check_flag("write-back beat count", 1'b1, wr_beats == (exp_wb ? 16 : 0));
			model_tag[way][idx]   = tag;
			model_valid[way][idx] = 1'b1;
			model_dirty[way][idx] = 1'b0;
		end

		model_lru[idx] = ~way;
		if (we)
		begin
			model_dirty[way][idx] = 1'b1;
			for (int b = 0; b < WORD_BYTES; b++)
			begin
				if (be[b])
					shadow[word][b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
	endtask

	initial
	begin
		rst_n       = 1'b0;
		cpu_req     = 1'b0;
		cpu_we      = 1'b0;
		cpu_addr    = '0;
		cpu_be      = '0;
		cpu_wdata   = '0;
		rng         = 32'h37cb;
		word_errors = 0;
		addr_errors = 0;
		flag_errors = 0;
		timeouts    = 0;
		model_lru   = '0;
		for (int w = 0; w < 2; w++)
		begin
			model_valid[w] = '0;
			model_dirty[w] = '0;
		end

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_flag("cpu_ready after reset", 1'b1, cpu_ready);
		check_flag("cpu_resp after reset", 1'b0, cpu_resp);
		check_flag("mem_arvalid after reset", 1'b0, mem_arvalid);
		check_flag("mem_awvalid after reset", 1'b0, mem_awvalid);
		check_flag("mem_wvalid after reset", 1'b0, mem_wvalid);
		check_flag("mem_wlast after reset", 1'b0, mem_wlast);

		// start from the slave's initial contents
		for (int i = 0; i < 2**MEM_AW; i++)
		begin
			shadow[i] = i_mem.mem[i];
		end

		for (int n = 0; (n < NUM_ACCESSES) && (timeouts == 0); n++)
		begin
			rng  = xorshift(rng);
			draw = rng;
			rng  = xorshift(rng);
			// four tags per set against two ways
			run_access(draw[0], {22'b0, draw[2:1], draw[4:3], draw[8:5], 2'b00}, draw[12:9],
				rng);
		end

		$display("errors: word %0d, addr %0d, flag %0d, timeouts %0d",
			word_errors, addr_errors, flag_errors, timeouts);
		if ((word_errors + addr_errors + flag_errors + timeouts) == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- build.f
logic/dcache_pkg.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/dcache_mem_slave.sv
sim/tb_dcache.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f --top-module tb_dcache -o tb_dcache
./obj_dir/tb_dcache | tee sim.log

if grep -qx "sim passed" sim.log; then
	echo "simulation OK"
else
	echo "simulation FAILED"
	exit 1
fi
